// ==== logic/busArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module busArbiter
    import memPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_pause,
    memBusIf.arbiter             dataBus,
    memBusIf.arbiter             instBus,
    input  logic [byteWidth-1:0] i_memData,
    output logic                 o_memWrite,
    output logic [addrWidth-1:0] o_memAddr,
    output logic [byteWidth-1:0] o_memData,
    output busOwnerT             o_busOwner
);
    busOwnerT owner;
    logic     selWrite;

    // bus goes back to none before the next owner is picked
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownerNone;
        end else if (!i_pause) begin
            case (owner)
                ownerNone: begin
                    // data side wins a tie
                    if (dataBus.req) begin
                        owner <= ownerData;
                    end else if (instBus.req) begin
                        owner <= ownerInst;
                    end
                end
                ownerData: begin
                    if (!dataBus.req) begin
                        owner <= ownerNone;
                    end
                end
                ownerInst: begin
                    if (!instBus.req) begin
                        owner <= ownerNone;
                    end
                end
                default: begin
                    owner <= ownerNone;
                end
            endcase
        end
    end

    assign dataBus.grant = (owner == ownerData);
    assign instBus.grant = (owner == ownerInst);

    assign dataBus.rdata = i_memData;
    assign instBus.rdata = i_memData;

    always_comb begin
        case (owner)
            ownerData: begin
                o_memAddr = dataBus.addr;
                selWrite  = dataBus.write;
                o_memData = dataBus.wdata;
            end
            ownerInst: begin
                o_memAddr = instBus.addr;
                selWrite  = instBus.write;
                o_memData = instBus.wdata;
            end
            default: begin
                o_memAddr = '0;
                selWrite  = 1'b0;
                o_memData = '0;
            end
        endcase
    end

    // no RAM writes while paused
    assign o_memWrite = selWrite && !i_pause;
    assign o_busOwner = owner;

endmodule

`default_nettype wire

// ==== logic/dataPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataPort
    import memPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_pause,
    input  logic                 i_dataEn,
    input  logic                 i_dataStore,
    input  logic [lenWidth-1:0]  i_dataLen,
    input  logic [addrWidth-1:0] i_dataAddr,
    input  logic [wordWidth-1:0] i_dataWdata,
    output logic                 o_dataDone,
    output logic [wordWidth-1:0] o_dataRdata,
    memBusIf.client              bus
);
    logic                                storeOp;
    logic [lenWidth-1:0]                 xferLen;
    logic [addrWidth-1:0]                baseAddr;
    logic [wordBytes-1:0][byteWidth-1:0] storeWord;
    logic [wordBytes-2:0][byteWidth-1:0] loadBytes;
    logic [wordBytes-1:0][byteWidth-1:0] loadWord;
    logic [lenWidth-1:0]                 byteCount;
    logic [lenWidth-1:0]                 lastCount;
    logic [lenWidth-1:0]                 addrOffset;
    logic [byteIdxWidth-1:0]             liveIdx;
    logic                                lastByte;
    logic                                capture;

    // request fields follow the inputs until the bus is granted
    always_ff @(posedge clk) begin
        if (!bus.grant) begin
            storeOp   <= i_dataStore;
            xferLen   <= i_dataLen;
            baseAddr  <= i_dataAddr;
            storeWord <= i_dataWdata;
        end
    end

    // a store ends with its last write, a load one cycle later with its last byte
    assign lastCount = storeOp ? xferLen - 1'b1 : xferLen;
    assign lastByte  = bus.grant && (byteCount == lastCount);

    always_ff @(posedge clk) begin
        if (rst) begin
            byteCount <= '0;
        end else if (!i_pause) begin
            if (!bus.grant || lastByte) begin
                byteCount <= '0;
            end else begin
                byteCount <= byteCount + 1'b1;
            end
        end
    end

    // load bytes below the last one are stored
    assign capture = bus.grant && !i_pause && !storeOp && (byteCount != '0) && !lastByte;

    always_ff @(posedge clk) begin
        if (capture) begin
            loadBytes[byteIdxWidth'(byteCount - 1'b1)] <= bus.rdata;
        end
    end

    // paused cycles hold the previous address as in fetchPort
    assign addrOffset = (i_pause && byteCount != '0) ? byteCount - 1'b1 : byteCount;

    assign bus.req   = i_dataEn && !lastByte;
    assign bus.addr  = baseAddr + addrWidth'(addrOffset);
    assign bus.write = storeOp;
    assign bus.wdata = storeWord[byteCount[byteIdxWidth-1:0]];

    // length 4 wraps to index 3
    assign liveIdx = xferLen[byteIdxWidth-1:0] - 1'b1;

    always_comb begin
        loadWord = '0;
        for (int i = 0; i < wordBytes - 1; i++) begin
            if (i < int'(liveIdx)) begin
                loadWord[i] = loadBytes[i];
            end
        end
        loadWord[liveIdx] = bus.rdata;
    end

    assign o_dataRdata = loadWord;
    assign o_dataDone  = lastByte && !i_pause;

endmodule

`default_nettype wire

// ==== logic/fetchPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchPort
    import memPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_pause,
    input  logic                 i_fetchEn,
    input  logic [addrWidth-1:0] i_fetchAddr,
    output logic                 o_fetchDone,
    output logic [wordWidth-1:0] o_fetchInst,
    memBusIf.client              bus
);
    logic [addrWidth-1:0]                  baseAddr;
    logic [lenWidth-1:0]                   byteCount;
    logic [lenWidth-1:0]                   addrOffset;
    logic [wordWidth-byteWidth-1:0]        shiftReg;
    logic                                  lastByte;
    logic                                  capture;

    // base follows the input until the bus is granted
    always_ff @(posedge clk) begin
        if (!bus.grant) begin
            baseAddr <= i_fetchAddr;
        end
    end

    assign lastByte = bus.grant && (byteCount == lenWidth'(wordBytes));

    always_ff @(posedge clk) begin
        if (rst) begin
            byteCount <= '0;
        end else if (!i_pause) begin
            if (!bus.grant || lastByte) begin
                byteCount <= '0;
            end else begin
                byteCount <= byteCount + 1'b1;
            end
        end
    end

    // byte for the previous address arrives now, first three go to the shifter
    assign capture = bus.grant && !i_pause && (byteCount != '0) && !lastByte;

    always_ff @(posedge clk) begin
        if (capture) begin
            shiftReg <= {bus.rdata, shiftReg[wordWidth-byteWidth-1:byteWidth]};
        end
    end

    // Paused cycles re-present the previous address, so the RAM keeps
    // returning the byte that is still waiting to be captured.
    assign addrOffset = (i_pause && byteCount != '0) ? byteCount - 1'b1 : byteCount;

    assign bus.req   = i_fetchEn && !lastByte;
    assign bus.addr  = baseAddr + addrWidth'(addrOffset);
    assign bus.write = 1'b0;
    assign bus.wdata = '0;

    // last byte comes straight off the bus
    assign o_fetchInst = {bus.rdata, shiftReg};
    assign o_fetchDone = lastByte && !i_pause;

endmodule

`default_nettype wire

// ==== logic/memBusIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface memBusIf
    import memPkg::*;
();
    logic                 req;
    logic                 grant;
    logic [addrWidth-1:0] addr;
    logic                 write;
    logic [byteWidth-1:0] wdata;
    logic [byteWidth-1:0] rdata;

    modport client (
        output req,
        output addr,
        output write,
        output wdata,
        input  grant,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  addr,
        input  write,
        input  wdata,
        output grant,
        output rdata
    );

endinterface

`default_nettype wire

// ==== logic/memCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtrl
    import memPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,
    input  logic                 i_ioBufferFull,
    input  logic [byteWidth-1:0] i_memData,
    output logic                 o_memWrite,
    output logic [addrWidth-1:0] o_memAddr,
    output logic [byteWidth-1:0] o_memData,
    output busOwnerT             o_busOwner,
    input  logic                 i_fetchEn,
    input  logic [addrWidth-1:0] i_fetchAddr,
    output logic                 o_fetchDone,
    output logic [wordWidth-1:0] o_fetchInst,
    input  logic                 i_dataEn,
    input  logic                 i_dataStore,
    input  logic [lenWidth-1:0]  i_dataLen,
    input  logic [addrWidth-1:0] i_dataAddr,
    input  logic [wordWidth-1:0] i_dataWdata,
    output logic                 o_dataDone,
    output logic [wordWidth-1:0] o_dataRdata
);
    logic pause;

    memBusIf dataBus ();
    memBusIf instBus ();

    // one freeze for every block
    assign pause = !i_rdy || i_ioBufferFull;

    busArbiter arbiter (
        .clk        (clk),
        .rst        (rst),
        .i_pause    (pause),
        .dataBus    (dataBus.arbiter),
        .instBus    (instBus.arbiter),
        .i_memData  (i_memData),
        .o_memWrite (o_memWrite),
        .o_memAddr  (o_memAddr),
        .o_memData  (o_memData),
        .o_busOwner (o_busOwner)
    );

    fetchPort fetch (
        .clk         (clk),
        .rst         (rst),
        .i_pause     (pause),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .bus         (instBus.client)
    );

    dataPort data (
        .clk         (clk),
        .rst         (rst),
        .i_pause     (pause),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .bus         (dataBus.client)
    );

endmodule

`default_nettype wire

// ==== logic/memPkg.sv ====
`default_nettype none

package memPkg;

    // RAM bus
    localparam int addrWidth = 32;
    localparam int byteWidth = 8;

    // client words
    localparam int wordWidth = 32;
    localparam int wordBytes = wordWidth / byteWidth;

    // byte counter and length field count 0 to wordBytes
    localparam int lenWidth = 3;
    localparam int byteIdxWidth = $clog2(wordBytes);

    typedef enum logic [1:0] {
        ownerNone = 2'd0,
        ownerData = 2'd1,
        ownerInst = 2'd2
    } busOwnerT;

endpackage

`default_nettype wire

// ==== memCtrl.f ====
logic/memPkg.sv
logic/memBusIf.sv
logic/busArbiter.sv
logic/fetchPort.sv
logic/dataPort.sv
logic/memCtrl.sv
tb/byteRam.sv
tb/memCtrlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f memCtrl.f --top-module memCtrlTb -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== tb/byteRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  logic        clk,
    input  logic [31:0] i_addr,
    input  logic        i_write,
    input  logic [7:0]  i_wdata,
    output logic [7:0]  o_rdata
);
    localparam int memBytes = 1024;

    logic [7:0] mem [0:memBytes-1];
    logic [9:0] index;

    assign index = i_addr[9:0];

    // preload with the low byte of a*7+3
    initial begin
        for (int a = 0; a < memBytes; a++) begin
            mem[a] = 8'(a * 7 + 3);
        end
        o_rdata = 8'h00;
    end

    // read data registered one cycle after the address
    always @(posedge clk) begin
        if (i_write) begin
            mem[index] <= i_wdata;
        end
        o_rdata <= mem[index];
    end

endmodule

`default_nettype wire

// ==== tb/memCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtrlTb
    import memPkg::*;
();
    localparam int resetCycles = 8;
    localparam int maxWords = 200;

    logic        clk;
    logic        rst;
    logic        i_rdy;
    logic        i_ioBufferFull;
    logic [7:0]  memRdata;
    logic        memWrite;
    logic [31:0] memAddr;
    logic [7:0]  memWdata;
    busOwnerT    busOwner;
    logic        i_fetchEn;
    logic [31:0] i_fetchAddr;
    logic        fetchDone;
    logic [31:0] fetchInst;
    logic        i_dataEn;
    logic        i_dataStore;
    logic [2:0]  i_dataLen;
    logic [31:0] i_dataAddr;
    logic [31:0] i_dataWdata;
    logic        dataDone;
    logic [31:0] dataRdata;

    logic [31:0] pats [0:maxWords-1];
    logic [7:0]  model [0:1023];
    logic [31:0] rng;
    logic        pauseOn;
    int          errorCount;
    int          cycleCount;
    int          limit;
    int          writeCount;
    int          dataGrantCycle;
    int          instGrantCycle;
    busOwnerT    prevOwner;
    logic [31:0] storeAddr;
    logic [31:0] storeWdata;
    string       curName;

    memCtrl uut (
        .clk(clk), .rst(rst), .i_rdy(i_rdy), .i_ioBufferFull(i_ioBufferFull),
        .i_memData(memRdata), .o_memWrite(memWrite), .o_memAddr(memAddr),
        .o_memData(memWdata), .o_busOwner(busOwner),
        .i_fetchEn(i_fetchEn), .i_fetchAddr(i_fetchAddr),
        .o_fetchDone(fetchDone), .o_fetchInst(fetchInst),
        .i_dataEn(i_dataEn), .i_dataStore(i_dataStore), .i_dataLen(i_dataLen),
        .i_dataAddr(i_dataAddr), .i_dataWdata(i_dataWdata),
        .o_dataDone(dataDone), .o_dataRdata(dataRdata)
    );

    byteRam ram (
        .clk(clk), .i_addr(memAddr), .i_write(memWrite),
        .i_wdata(memWdata), .o_rdata(memRdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // little-endian word zero-extended above len
    function automatic logic [31:0] readModel(input logic [31:0] addr, input int len);
        logic [31:0] r;
        r = 32'h0;
        for (int i = 0; i < len; i++) begin
            r[8*i +: 8] = model[10'(addr + 32'(i))];
        end
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            errorCount++;
            $display("error %s: expected %h actual %h", name, expVal, actVal);
        end
    endtask

    task automatic checkIdle(input string when);
        assert (!fetchDone && !dataDone && !memWrite && busOwner == ownerNone) else begin
            errorCount++;
            $display("controller not idle %s", when);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random pauses only while a paused pattern runs
    always @(posedge clk) begin
        cycleCount++;
        if (pauseOn) begin
            rng = xorshift(rng);
            i_rdy <= (rng[2:0] != 3'd0);
            i_ioBufferFull <= (rng[6:4] == 3'd0);
        end else begin
            i_rdy <= 1'b1;
            i_ioBufferFull <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (!i_rdy || i_ioBufferFull) begin
            assert (!memWrite && !fetchDone && !dataDone) else begin
                errorCount++;
                $display("write or done seen while paused in cycle %0d", cycleCount);
            end
        end
        // byte i of a store goes to base+i
        if (memWrite) begin
            checkValue({curName, " write address"}, storeAddr + 32'(writeCount), memAddr);
            checkValue({curName, " write byte"}, 32'(storeWdata[8*writeCount +: 8]),
                       32'(memWdata));
            writeCount++;
        end
        if (busOwner == ownerData && prevOwner != ownerData && dataGrantCycle < 0) begin
            dataGrantCycle = cycleCount;
        end
        if (busOwner == ownerInst && prevOwner != ownerInst && instGrantCycle < 0) begin
            instGrantCycle = cycleCount;
        end
        prevOwner = busOwner;
    end

    initial begin
        @(negedge clk);
        while (cycleCount < limit) begin
            @(negedge clk);
        end
        $display("timeout after %0d cycles, a done never arrived", cycleCount);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic runTransfer(input int idx, input logic [31:0] op, input logic [31:0] len,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [31:0] listed);
        logic [2:0]  kind;
        logic [31:0] dataExp;
        logic [31:0] fetchExp;
        logic [31:0] dataGot;
        logic [31:0] fetchGot;
        logic        dataWait;
        logic        fetchWait;
        int          dataDoneCycle;
        int          fetchDoneCycle;
        string       name;
        kind = op[2:0];
        name = $sformatf("pattern %0d", idx);
        dataExp = readModel(addr, int'(len));
        fetchExp = readModel(kind == 3'd3 ? wdata : addr, 4);
        dataWait = (kind != 3'd0);
        fetchWait = (kind == 3'd0 || kind == 3'd3);
        dataDoneCycle = 0;
        fetchDoneCycle = 0;
        dataGot = 32'h0;
        fetchGot = 32'h0;

        @(posedge clk);
        pauseOn <= op[3];
        writeCount = 0;
        dataGrantCycle = -1;
        instGrantCycle = -1;
        curName = name;
        storeAddr = addr;
        storeWdata = wdata;
        if (fetchWait) begin
            i_fetchEn <= 1'b1;
            i_fetchAddr <= (kind == 3'd3) ? wdata : addr;
        end
        if (dataWait) begin
            i_dataEn <= 1'b1;
            i_dataStore <= (kind == 3'd2);
            i_dataLen <= len[2:0];
            i_dataAddr <= addr;
            i_dataWdata <= wdata;
        end

        while (dataWait || fetchWait) begin
            @(negedge clk);
            if (dataWait && dataDone) begin
                dataWait = 1'b0;
                dataGot = dataRdata;
                dataDoneCycle = cycleCount;
                checkValue({name, " data owner"}, 32'(ownerData), 32'(busOwner));
            end
            if (fetchWait && fetchDone) begin
                fetchWait = 1'b0;
                fetchGot = fetchInst;
                fetchDoneCycle = cycleCount;
                checkValue({name, " fetch owner"}, 32'(ownerInst), 32'(busOwner));
            end
            @(posedge clk);
            if (!dataWait) begin
                i_dataEn <= 1'b0;
            end
            if (!fetchWait) begin
                i_fetchEn <= 1'b0;
            end
        end

        if (kind == 3'd0 || kind == 3'd3) begin
            checkValue({name, " fetch"}, fetchExp, fetchGot);
            if (kind == 3'd0) begin
                checkValue({name, " fetch listed"}, listed, fetchGot);
            end
            if (!op[3]) begin
                checkValue({name, " fetch timing"}, 32'd4,
                           32'(fetchDoneCycle - instGrantCycle));
            end
        end
        if (kind == 3'd1 || kind == 3'd3) begin
            checkValue({name, " load model"}, dataExp, dataGot);
            checkValue({name, " load listed"}, listed, dataGot);
            if (!op[3]) begin
                checkValue({name, " load timing"}, len, 32'(dataDoneCycle - dataGrantCycle));
            end
        end
        if (kind == 3'd2) begin
            checkValue({name, " store writes"}, len, 32'(writeCount));
            if (!op[3]) begin
                checkValue({name, " store timing"}, len - 32'd1,
                           32'(dataDoneCycle - dataGrantCycle));
            end
            for (int i = 0; i < int'(len); i++) begin
                model[10'(addr + 32'(i))] = wdata[8*i +: 8];
            end
        end else begin
            checkValue({name, " load writes"}, 32'd0, 32'(writeCount));
        end
        // data first when both rise together
        if (kind == 3'd3) begin
            assert (dataGrantCycle >= 0 && dataGrantCycle < instGrantCycle
                    && dataDoneCycle < fetchDoneCycle) else begin
                errorCount++;
                $display("%s: fetch was served before the data port", name);
            end
            // waiting fetch is granted two cycles after the data done
            if (!op[3]) begin
                checkValue({name, " next grant"}, 32'd2,
                           32'(instGrantCycle - dataDoneCycle));
            end
        end
    endtask

    initial begin
        int count;
        rst = 1'b1;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        i_fetchEn = 1'b0;
        i_fetchAddr = 32'h0;
        i_dataEn = 1'b0;
        i_dataStore = 1'b0;
        i_dataLen = 3'd0;
        i_dataAddr = 32'h0;
        i_dataWdata = 32'h0;
        pauseOn = 1'b0;
        rng = 32'h17af;
        errorCount = 0;
        cycleCount = 0;
        writeCount = 0;
        dataGrantCycle = -1;
        instGrantCycle = -1;
        prevOwner = ownerNone;
        storeAddr = 32'h0;
        storeWdata = 32'h0;
        curName = "reset";
        for (int a = 0; a < 1024; a++) begin
            model[a] = 8'(a * 7 + 3);
        end
        for (int w = 0; w < maxWords; w++) begin
            pats[w] = 32'hffffffff;
        end
        $readmemh("tb/memCtrl_patterns.txt", pats);
        count = 0;
        while (5 * count < maxWords && pats[5*count] !== 32'hffffffff) begin
            count++;
        end
        limit = count * 20 + resetCycles;

        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
            if (i == resetCycles - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            checkIdle("during reset");
        end
        @(negedge clk);
        checkIdle("after reset");

        for (int p = 0; p < count; p++) begin
            runTransfer(p, pats[5*p], pats[5*p+1], pats[5*p+2], pats[5*p+3], pats[5*p+4]);
        end

        $display("errors: %0d in %0d patterns", errorCount, count);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/memCtrl_patterns.txt ====
// op len addr wdata expected, one transfer per line
// op: 0 fetch, 1 load, 2 store, 3 load plus fetch at wdata, +8 random pauses
0 4 00000010 00000000 88817a73
1 1 00000020 00000000 000000e3
1 2 00000021 00000000 0000f1ea
1 4 00000040 00000000 d8d1cac3
2 2 00000080 11223344 00000000
1 4 00000080 00000000 98913344
2 1 00000090 000000a5 00000000
1 4 00000090 00000000 0801faa5
2 4 000000a0 deadbeef 00000000
1 4 000000a0 00000000 deadbeef
3 4 00000100 00000200 18110a03
1 4 00000200 00000000 18110a03
8 4 00000030 00000000 68615a53
9 2 00000041 00000000 0000d1ca
a 4 000000b0 cafef00d 00000000
9 4 000000b0 00000000 cafef00d
a 2 000000c0 00005a5a 00000000
9 4 000000c0 00000000 58515a5a
b 1 000000a1 00000010 000000be
9 4 000000a0 00000000 deadbeef
9 1 00000020 00000000 000000e3
1 4 000000b0 00000000 cafef00d
ffffffff
